// File: design/id_cfg.svh
// decode stage widths
`ifndef ID_CFG_SVH
`define ID_CFG_SVH

// data path and pc width
`define XLEN 64

// fetched instruction word
`define INST_WD 32

// general register file
`define GPR_ADDR_WD 5
`define GPR_NUM 32

`endif

// File: design/rv_isa_pkg.sv
// rv64i instruction encodings
`default_nettype none

package rv_isa_pkg;

  `include "id_cfg.svh"

  typedef enum logic [6:0] {
    OPC_LOAD      = 7'b0000011,
    OPC_OP_IMM    = 7'b0010011,
    OPC_AUIPC     = 7'b0010111,
    OPC_OP_IMM_32 = 7'b0011011,
    OPC_STORE     = 7'b0100011,
    OPC_OP        = 7'b0110011,
    OPC_LUI       = 7'b0110111,
    OPC_OP_32     = 7'b0111011,
    OPC_BRANCH    = 7'b1100011,
    OPC_JALR      = 7'b1100111,
    OPC_JAL       = 7'b1101111
  } opcode_e;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_e    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_fmt_t;

  // one fetched word, viewed per format
  typedef union packed {
    logic [`INST_WD-1:0] raw;
    r_fmt_t              r;
    i_fmt_t              i;
    s_fmt_t              s;
    b_fmt_t              b;
    u_fmt_t              u;
    j_fmt_t              j;
  } rv_inst_u;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_LUI
  } alu_op_e;

  // low 3 bits of a conditional branch are its funct3
  typedef enum logic [3:0] {
    BR_NONE = 4'b0000,
    BR_JAL  = 4'b0001,
    BR_JALR = 4'b0010,
    BR_BEQ  = 4'b1000,
    BR_BNE  = 4'b1001,
    BR_BLT  = 4'b1100,
    BR_BGE  = 4'b1101,
    BR_BLTU = 4'b1110,
    BR_BGEU = 4'b1111
  } br_func_e;

  typedef enum logic [1:0] {
    SRC2_RS2  = 2'd0,
    SRC2_IMM  = 2'd1,
    SRC2_FOUR = 2'd2 // link address for jal/jalr
  } src2_sel_e;

endpackage

`default_nettype wire

// File: design/id_bus_pkg.sv
// pipeline stage buses
`default_nettype none

package id_bus_pkg;

  `include "id_cfg.svh"

  typedef struct packed {
    logic [`INST_WD-1:0] inst;
    logic [`XLEN-1:0]    pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic                    wen;
    logic [`GPR_ADDR_WD-1:0] waddr;
    logic [`XLEN-1:0]        wdata;
  } ws_to_rf_t;

  // redirect to fetch
  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } br_bus_t;

  typedef struct packed {
    logic [`XLEN-1:0]        rs1_data;
    logic [`XLEN-1:0]        rs2_data;
    logic [`XLEN-1:0]        imm;
    logic [`XLEN-1:0]        pc;
    logic                    src1_pc_sel;
    rv_isa_pkg::src2_sel_e   src2_sel;
    rv_isa_pkg::alu_op_e     alu_op;
    logic                    word_op; // 32-bit result, sign extended
    logic [`GPR_ADDR_WD-1:0] rd;
    logic                    gpr_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    logic [2:0]              mem_op;  // funct3 of load/store
    logic                    invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic [`GPR_ADDR_WD-1:0] rs1;
    logic [`GPR_ADDR_WD-1:0] rs2;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        imm;
    logic                    uses_rs1;
    logic                    uses_rs2;
    rv_isa_pkg::br_func_e    br_func;
    logic                    src1_pc_sel;
    rv_isa_pkg::src2_sel_e   src2_sel;
    rv_isa_pkg::alu_op_e     alu_op;
    logic                    word_op;
    logic                    gpr_wen;
    logic                    mem_ren;
    logic                    mem_wen;
    logic [2:0]              mem_op;
    logic                    invalid;
  } dec_ctrl_t;

endpackage

`default_nettype wire

// File: design/id_decoder.sv
// instruction decoder
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_decoder (
  input  rv_isa_pkg::rv_inst_u  i_inst,
  output id_bus_pkg::dec_ctrl_t o_ctrl
);

  logic [2:0]       funct3;
  logic [6:0]       funct7;
  logic             illegal;
  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_j;

  function automatic rv_isa_pkg::alu_op_e alu_of_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      3'b001:  return rv_isa_pkg::ALU_SLL;
      3'b010:  return rv_isa_pkg::ALU_SLT;
      3'b011:  return rv_isa_pkg::ALU_SLTU;
      3'b100:  return rv_isa_pkg::ALU_XOR;
      3'b101:  return alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      3'b110:  return rv_isa_pkg::ALU_OR;
      default: return rv_isa_pkg::ALU_AND;
    endcase
  endfunction

  assign funct3 = i_inst.r.funct3;
  assign funct7 = i_inst.r.funct7;

  assign imm_i = {{(`XLEN-12){i_inst.i.imm_11_0[11]}}, i_inst.i.imm_11_0};
  assign imm_s = {{(`XLEN-12){i_inst.s.imm_11_5[6]}}, i_inst.s.imm_11_5, i_inst.s.imm_4_0};
  assign imm_b = {{(`XLEN-13){i_inst.b.imm_12}}, i_inst.b.imm_12, i_inst.b.imm_11,
                  i_inst.b.imm_10_5, i_inst.b.imm_4_1, 1'b0};
  assign imm_u = {{(`XLEN-32){i_inst.u.imm_31_12[19]}}, i_inst.u.imm_31_12, 12'b0};
  assign imm_j = {{(`XLEN-21){i_inst.j.imm_20}}, i_inst.j.imm_20, i_inst.j.imm_19_12,
                  i_inst.j.imm_11, i_inst.j.imm_10_1, 1'b0};

  always_comb begin
    illegal         = 1'b0;
    o_ctrl          = '0;
    o_ctrl.rs1      = i_inst.r.rs1;
    o_ctrl.rs2      = i_inst.r.rs2;
    o_ctrl.rd       = i_inst.r.rd;
    o_ctrl.br_func  = rv_isa_pkg::BR_NONE;
    o_ctrl.src2_sel = rv_isa_pkg::SRC2_RS2;
    o_ctrl.alu_op   = rv_isa_pkg::ALU_ADD;
    o_ctrl.mem_op   = funct3;
    case (i_inst.r.opcode)
      rv_isa_pkg::OPC_OP, rv_isa_pkg::OPC_OP_32: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.word_op  = (i_inst.r.opcode == rv_isa_pkg::OPC_OP_32);
        o_ctrl.alu_op   = alu_of_f3(funct3, funct7[5]);
        illegal = !(funct7 == 7'h00 || (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
        // word forms only have add/sub and shifts
        if (o_ctrl.word_op && !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101)) begin
          illegal = 1'b1;
        end
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.imm      = imm_i;
        o_ctrl.src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.alu_op   = alu_of_f3(funct3, funct3 == 3'b101 && funct7[5]);
        if (funct3 == 3'b001) illegal = (funct7[6:1] != 6'h00); // 6-bit shamt
        if (funct3 == 3'b101) illegal = (funct7[6:1] != 6'h00 && funct7[6:1] != 6'h10);
      end
      rv_isa_pkg::OPC_OP_IMM_32: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.word_op  = 1'b1;
        o_ctrl.imm      = imm_i;
        o_ctrl.src2_sel = rv_isa_pkg::SRC2_IMM;
        o_ctrl.alu_op   = alu_of_f3(funct3, funct3 == 3'b101 && funct7[5]);
        case (funct3)
          3'b000:  illegal = 1'b0;
          3'b001:  illegal = (funct7 != 7'h00);
          3'b101:  illegal = !(funct7 == 7'h00 || funct7 == 7'h20);
          default: illegal = 1'b1;
        endcase
      end
      rv_isa_pkg::OPC_LUI, rv_isa_pkg::OPC_AUIPC: begin
        o_ctrl.gpr_wen     = 1'b1;
        o_ctrl.imm         = imm_u;
        o_ctrl.src2_sel    = rv_isa_pkg::SRC2_IMM;
        o_ctrl.src1_pc_sel = (i_inst.r.opcode == rv_isa_pkg::OPC_AUIPC);
        if (i_inst.r.opcode == rv_isa_pkg::OPC_LUI) o_ctrl.alu_op = rv_isa_pkg::ALU_LUI;
      end
      rv_isa_pkg::OPC_JAL, rv_isa_pkg::OPC_JALR: begin
        o_ctrl.gpr_wen     = 1'b1;
        o_ctrl.src1_pc_sel = 1'b1; // rd gets pc + 4
        o_ctrl.src2_sel    = rv_isa_pkg::SRC2_FOUR;
        if (i_inst.r.opcode == rv_isa_pkg::OPC_JAL) begin
          o_ctrl.imm     = imm_j;
          o_ctrl.br_func = rv_isa_pkg::BR_JAL;
        end else begin
          o_ctrl.uses_rs1 = 1'b1;
          o_ctrl.imm      = imm_i;
          o_ctrl.br_func  = rv_isa_pkg::BR_JALR;
          illegal         = (funct3 != 3'b000);
        end
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        o_ctrl.imm      = imm_b;
        o_ctrl.br_func  = rv_isa_pkg::br_func_e'({1'b1, funct3});
        illegal         = (funct3[2:1] == 2'b01);
      end
      rv_isa_pkg::OPC_LOAD: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.mem_ren  = 1'b1;
        o_ctrl.imm      = imm_i;
        o_ctrl.src2_sel = rv_isa_pkg::SRC2_IMM;
        illegal         = (funct3 == 3'b111);
      end
      rv_isa_pkg::OPC_STORE: begin
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        o_ctrl.mem_wen  = 1'b1;
        o_ctrl.imm      = imm_s;
        o_ctrl.src2_sel = rv_isa_pkg::SRC2_IMM;
        illegal         = funct3[2];
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin
      o_ctrl.invalid  = 1'b1;
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.mem_ren  = 1'b0;
      o_ctrl.mem_wen  = 1'b0;
      o_ctrl.uses_rs1 = 1'b0;
      o_ctrl.uses_rs2 = 1'b0;
      o_ctrl.br_func  = rv_isa_pkg::BR_NONE;
    end
    if (!o_ctrl.gpr_wen) o_ctrl.rd = '0; // zero rd means no pending write downstream
  end

  // funct-code checks in every opcode arm must all feed the same invalid path
  always_comb begin
    a_invalid_no_wen: assert (!(o_ctrl.invalid && o_ctrl.gpr_wen));
  end

endmodule

`default_nettype wire

// File: design/id_gpr_file.sv
// general register file
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_gpr_file (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [`GPR_ADDR_WD-1:0] i_raddr2,
  output logic [`XLEN-1:0]        o_rdata1,
  output logic [`XLEN-1:0]        o_rdata2,
  input  id_bus_pkg::ws_to_rf_t   i_wr
);

  logic [`XLEN-1:0] regs [`GPR_NUM];

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int k = 0; k < `GPR_NUM; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wr.wen && i_wr.waddr != '0) begin
      regs[i_wr.waddr] <= i_wr.wdata;
    end
  end

  // no bypass so the stall covers the write gap
  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  // x0 stays zero across writeback traffic
  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_raddr1 == '0) |-> (o_rdata1 == '0));

endmodule

`default_nettype wire

// File: design/id_branch_unit.sv
// branch resolution
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_branch_unit (
  input  logic                 i_valid,
  input  rv_isa_pkg::br_func_e i_br_func,
  input  logic [`XLEN-1:0]     i_rs1_data,
  input  logic [`XLEN-1:0]     i_rs2_data,
  input  logic [`XLEN-1:0]     i_pc,
  input  logic [`XLEN-1:0]     i_imm,
  output id_bus_pkg::br_bus_t  o_br_bus
);

  logic             eq;
  logic             lt_s;
  logic             lt_u;
  logic             cond;
  logic [`XLEN-1:0] jalr_sum;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_func)
      rv_isa_pkg::BR_BEQ:  cond = eq;
      rv_isa_pkg::BR_BNE:  cond = !eq;
      rv_isa_pkg::BR_BLT:  cond = lt_s;
      rv_isa_pkg::BR_BGE:  cond = !lt_s;
      rv_isa_pkg::BR_BLTU: cond = lt_u;
      rv_isa_pkg::BR_BGEU: cond = !lt_u;
      rv_isa_pkg::BR_JAL,
      rv_isa_pkg::BR_JALR: cond = 1'b1;
      default:             cond = 1'b0;
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_br_bus.taken  = i_valid && cond;
  assign o_br_bus.target = (i_br_func == rv_isa_pkg::BR_JALR) ?
                           {jalr_sum[`XLEN-1:1], 1'b0} : // lsb cleared
                           i_pc + i_imm;

endmodule

`default_nettype wire

// File: design/id_stage_ctrl.sv
// decode stage handshake
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_stage_ctrl (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  input  logic                    i_es_allowin,
  input  logic [`GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ws_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_rs1,
  input  logic [`GPR_ADDR_WD-1:0] i_rs2,
  input  logic                    i_uses_rs1,
  input  logic                    i_uses_rs2,
  output logic                    o_ds_allowin,
  output logic                    o_ds_to_es_valid,
  output logic [`INST_WD-1:0]     o_inst,
  output logic [`XLEN-1:0]        o_pc
);

  logic                  ds_valid;
  logic                  ds_ready_go;
  id_bus_pkg::fs_to_ds_t fs_to_ds_r;

  // pending write in a later stage hits one of our sources
  function automatic logic rd_hit(input logic [`GPR_ADDR_WD-1:0] rd);
    return (rd != '0) && ((i_uses_rs1 && rd == i_rs1) || (i_uses_rs2 && rd == i_rs2));
  endfunction

  always_comb begin
    ds_ready_go = !(rd_hit(i_es_rd) || rd_hit(i_ms_rd) || rd_hit(i_ws_rd));
  end

  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      fs_to_ds_r <= i_fs_to_ds_bus;
    end
  end

  assign o_inst = fs_to_ds_r.inst;
  assign o_pc   = fs_to_ds_r.pc;

  a_out_valid: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_ds_to_es_valid |-> ds_valid);

  // back-pressure from execute freezes the held instruction
  a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (o_ds_to_es_valid && !i_es_allowin) |=> ($stable(o_pc) && $stable(o_inst)));

endmodule

`default_nettype wire

// File: design/id_stage.sv
// instruction decode stage
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module id_stage (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  input  logic                    i_fs_to_ds_valid,
  input  id_bus_pkg::fs_to_ds_t   i_fs_to_ds_bus,
  input  logic                    i_es_allowin,
  input  id_bus_pkg::ws_to_rf_t   i_ws_to_rf,
  input  logic [`GPR_ADDR_WD-1:0] i_es_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ms_rd,
  input  logic [`GPR_ADDR_WD-1:0] i_ws_rd,
  output logic                    o_ds_allowin,
  output logic                    o_ds_to_es_valid,
  output id_bus_pkg::ds_to_es_t   o_ds_to_es_bus,
  output id_bus_pkg::br_bus_t     o_br_bus
);

  id_bus_pkg::dec_ctrl_t ctrl;
  logic [`INST_WD-1:0]   ds_inst;
  logic [`XLEN-1:0]      ds_pc;
  logic [`XLEN-1:0]      rs1_data;
  logic [`XLEN-1:0]      rs2_data;

  id_stage_ctrl u_ctrl (
    .i_clk            (i_clk           ),
    .i_rst_n          (i_rst_n         ),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus  ),
    .i_es_allowin     (i_es_allowin    ),
    .i_es_rd          (i_es_rd         ),
    .i_ms_rd          (i_ms_rd         ),
    .i_ws_rd          (i_ws_rd         ),
    .i_rs1            (ctrl.rs1        ),
    .i_rs2            (ctrl.rs2        ),
    .i_uses_rs1       (ctrl.uses_rs1   ),
    .i_uses_rs2       (ctrl.uses_rs2   ),
    .o_ds_allowin     (o_ds_allowin    ),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst         ),
    .o_pc             (ds_pc           )
  );

  id_decoder u_decoder (
    .i_inst (ds_inst),
    .o_ctrl (ctrl   )
  );

  id_gpr_file u_gpr (
    .i_clk    (i_clk     ),
    .i_rst_n  (i_rst_n   ),
    .i_raddr1 (ctrl.rs1  ),
    .i_raddr2 (ctrl.rs2  ),
    .o_rdata1 (rs1_data  ),
    .o_rdata2 (rs2_data  ),
    .i_wr     (i_ws_to_rf)
  );

  // redirect only for an instruction actually leaving decode
  id_branch_unit u_bru (
    .i_valid    (o_ds_to_es_valid),
    .i_br_func  (ctrl.br_func    ),
    .i_rs1_data (rs1_data        ),
    .i_rs2_data (rs2_data        ),
    .i_pc       (ds_pc           ),
    .i_imm      (ctrl.imm        ),
    .o_br_bus   (o_br_bus        )
  );

  always_comb begin
    o_ds_to_es_bus.rs1_data    = rs1_data;
    o_ds_to_es_bus.rs2_data    = rs2_data;
    o_ds_to_es_bus.imm         = ctrl.imm;
    o_ds_to_es_bus.pc          = ds_pc;
    o_ds_to_es_bus.src1_pc_sel = ctrl.src1_pc_sel;
    o_ds_to_es_bus.src2_sel    = ctrl.src2_sel;
    o_ds_to_es_bus.alu_op      = ctrl.alu_op;
    o_ds_to_es_bus.word_op     = ctrl.word_op;
    o_ds_to_es_bus.rd          = ctrl.rd;
    o_ds_to_es_bus.gpr_wen     = ctrl.gpr_wen;
    o_ds_to_es_bus.mem_ren     = ctrl.mem_ren;
    o_ds_to_es_bus.mem_wen     = ctrl.mem_wen;
    o_ds_to_es_bus.mem_op      = ctrl.mem_op;
    o_ds_to_es_bus.invalid     = ctrl.invalid;
  end

endmodule

`default_nettype wire

// File: verif/tb_id_stage.sv
// decode stage testbench
`timescale 1ns/1ps
`default_nettype none

`include "id_cfg.svh"

module tb_id_stage;

  localparam int K_WB = 0;
  localparam int K_ISSUE = 1;

  typedef struct {
    int                      kind;
    logic [`INST_WD-1:0]     inst;
    logic [`XLEN-1:0]        pc;
    logic [`GPR_ADDR_WD-1:0] es_rd, ms_rd, ws_rd, wb_addr;
    logic                    allowin, stall;
    logic [`XLEN-1:0]        wb_data;
    logic [`GPR_ADDR_WD-1:0] rd;
    logic [`XLEN-1:0]        imm;
    logic [4:0]              alu;
    logic                    wen, inv, word, mren, mwen, taken;
    logic [2:0]              mop;
    logic [1:0]              src2;
    logic                    pcsel;
    logic [`XLEN-1:0]        target;
  } row_t;

  logic                    i_clk, i_rst_n, i_fs_to_ds_valid, i_es_allowin;
  id_bus_pkg::fs_to_ds_t   i_fs_to_ds_bus;
  id_bus_pkg::ws_to_rf_t   i_ws_to_rf;
  logic [`GPR_ADDR_WD-1:0] i_es_rd, i_ms_rd, i_ws_rd;
  logic                    o_ds_allowin, o_ds_to_es_valid;
  id_bus_pkg::ds_to_es_t   o_ds_to_es_bus;
  id_bus_pkg::br_bus_t     o_br_bus;

  row_t             tbl[$];
  row_t             cur;
  logic [`XLEN-1:0] shadow [`GPR_NUM];
  int               errors = 0;
  int               seed = 49239;
  logic             tbl_ready = 1'b0;

  id_stage UUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
    rv_isa_pkg::rv_inst_u u;
    u.r.funct7 = f7;
    u.r.rs2 = rs2;
    u.r.rs1 = rs1;
    u.r.funct3 = f3;
    u.r.rd = rd;
    u.r.opcode = rv_isa_pkg::opcode_e'(opc);
    return u.raw;
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd, input rv_isa_pkg::opcode_e opc);
    rv_isa_pkg::rv_inst_u u;
    u.i.imm_11_0 = imm;
    u.i.rs1 = rs1;
    u.i.funct3 = f3;
    u.i.rd = rd;
    u.i.opcode = opc;
    return u.raw;
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    rv_isa_pkg::rv_inst_u u;
    u.s.imm_11_5 = imm[11:5];
    u.s.rs2 = rs2;
    u.s.rs1 = rs1;
    u.s.funct3 = f3;
    u.s.imm_4_0 = imm[4:0];
    u.s.opcode = rv_isa_pkg::OPC_STORE;
    return u.raw;
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3);
    rv_isa_pkg::rv_inst_u u;
    u.b.imm_12 = off[12];
    u.b.imm_11 = off[11];
    u.b.imm_10_5 = off[10:5];
    u.b.imm_4_1 = off[4:1];
    u.b.rs2 = rs2;
    u.b.rs1 = rs1;
    u.b.funct3 = f3;
    u.b.opcode = rv_isa_pkg::OPC_BRANCH;
    return u.raw;
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    rv_isa_pkg::rv_inst_u u;
    u.u.imm_31_12 = imm;
    u.u.rd = rd;
    u.u.opcode = rv_isa_pkg::OPC_LUI;
    return u.raw;
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    rv_isa_pkg::rv_inst_u u;
    u.j.imm_20 = off[20];
    u.j.imm_19_12 = off[19:12];
    u.j.imm_11 = off[11];
    u.j.imm_10_1 = off[10:1];
    u.j.rd = rd;
    u.j.opcode = rv_isa_pkg::OPC_JAL;
    return u.raw;
  endfunction

  task automatic add_wb(input logic [4:0] addr, input logic [`XLEN-1:0] data);
    cur = '{default: '0};
    cur.kind = K_WB;
    cur.wb_addr = addr;
    cur.wb_data = data;
    tbl.push_back(cur);
  endtask

  // fills defaults for the caller to edit and push
  task automatic new_issue(input logic [31:0] inst, input logic [`XLEN-1:0] pc,
      input logic [4:0] rd, input logic [`XLEN-1:0] imm, input logic [4:0] alu,
      input logic wen);
    cur = '{default: '0};
    cur.kind = K_ISSUE;
    cur.inst = inst;
    cur.pc = pc;
    cur.allowin = 1'b1;
    cur.rd = rd;
    cur.imm = imm;
    cur.alu = alu;
    cur.wen = wen;
  endtask

  task automatic check(input string name, input logic [`XLEN-1:0] got,
      input logic [`XLEN-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic wait_out_valid();
    int n;
    n = 0;
    @(negedge i_clk);
    while (!o_ds_to_es_valid && n < 10) begin
      n++;
      @(negedge i_clk);
    end
    if (!o_ds_to_es_valid) begin
      errors++;
      $display("decode output never became valid");
    end
  endtask

  task automatic check_outputs(input row_t r);
    check("rd", o_ds_to_es_bus.rd, r.rd);
    check("imm", o_ds_to_es_bus.imm, r.imm);
    check("pc", o_ds_to_es_bus.pc, r.pc);
    check("alu_op", o_ds_to_es_bus.alu_op, r.alu);
    check("src1_pc_sel", o_ds_to_es_bus.src1_pc_sel, r.pcsel);
    check("src2_sel", o_ds_to_es_bus.src2_sel, r.src2);
    check("gpr_wen", o_ds_to_es_bus.gpr_wen, r.wen);
    check("invalid", o_ds_to_es_bus.invalid, r.inv);
    check("word_op", o_ds_to_es_bus.word_op, r.word);
    check("mem_ren", o_ds_to_es_bus.mem_ren, r.mren);
    check("mem_wen", o_ds_to_es_bus.mem_wen, r.mwen);
    if (r.mren || r.mwen) check("mem_op", o_ds_to_es_bus.mem_op, r.mop);
    check("rs1_data", o_ds_to_es_bus.rs1_data, shadow[r.inst[19:15]]);
    check("rs2_data", o_ds_to_es_bus.rs2_data, shadow[r.inst[24:20]]);
    check("taken", o_br_bus.taken, r.taken);
    if (r.taken) check("target", o_br_bus.target, r.target);
  endtask

  task automatic apply_row(input row_t r);
    @(posedge i_clk);
    #5;
    if (r.kind == K_WB) begin
      i_ws_to_rf = '{wen: 1'b1, waddr: r.wb_addr, wdata: r.wb_data};
      @(posedge i_clk);
      #5;
      i_ws_to_rf.wen = 1'b0;
      if (r.wb_addr != '0) shadow[r.wb_addr] = r.wb_data;
    end else begin
      i_fs_to_ds_valid = 1'b1;
      i_fs_to_ds_bus = '{inst: r.inst, pc: r.pc};
      i_es_rd = r.es_rd;
      i_ms_rd = r.ms_rd;
      i_ws_rd = r.ws_rd;
      i_es_allowin = r.allowin;
      @(negedge i_clk);
      while (!o_ds_allowin) @(negedge i_clk);
      @(posedge i_clk);
      #5;
      i_fs_to_ds_valid = 1'b0;
      if (r.stall) begin
        @(negedge i_clk);
        check("stall o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
        check("stall o_ds_allowin", o_ds_allowin, 1'b0);
        @(posedge i_clk);
        #5;
        i_es_rd = '0;
        i_ms_rd = '0;
        i_ws_rd = '0;
      end
      wait_out_valid();
      check_outputs(r);
      if (!r.allowin) begin
        check("hold o_ds_allowin", o_ds_allowin, 1'b0);
        repeat (3) begin
          @(negedge i_clk);
          check_outputs(r);
          check("hold o_ds_to_es_valid", o_ds_to_es_valid, 1'b1);
        end
        @(posedge i_clk);
        #5;
        i_es_allowin = 1'b1;
      end
    end
  endtask

  initial begin
    for (int k = 0; k < `GPR_NUM; k++) shadow[k] = '0;
    add_wb(5'd1, {$random(seed), $random(seed)});
    add_wb(5'd2, {$random(seed), $random(seed)});
    add_wb(5'd0, {$random(seed), $random(seed)}); // x0 must stay zero
    add_wb(5'd5, 64'hffff_ffff_ffff_fffb);
    add_wb(5'd6, 64'd7);
    add_wb(5'd7, 64'd7);
    new_issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd10, 7'h33), 64'h100, 5'd10, 0, 5'd0, 1);
    tbl.push_back(cur);
    new_issue(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd11, 7'h33), 64'h104, 5'd11, 0, 5'd1, 1);
    tbl.push_back(cur);
    new_issue(enc_i(12'hffd, 5'd1, 3'b000, 5'd12, rv_isa_pkg::OPC_OP_IMM_32), 64'h108, 5'd12,
              64'hffff_ffff_ffff_fffd, 5'd0, 1);
    cur.word = 1'b1;
    cur.src2 = 2'd1;
    tbl.push_back(cur);
    new_issue(enc_u(20'h80001, 5'd13), 64'h10c, 5'd13, 64'hffff_ffff_8000_1000, 5'd10, 1);
    cur.src2 = 2'd1;
    tbl.push_back(cur);
    new_issue(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd14, 7'h33), 64'h110, 5'd14, 0, 5'd0, 1);
    tbl.push_back(cur);
    new_issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd15, 7'h33), 64'h114, 5'd15, 0, 5'd0, 1);
    cur.es_rd = 5'd2;
    cur.stall = 1'b1;
    tbl.push_back(cur);
    // rs2 field holds imm bits so a hazard there is ignored
    new_issue(enc_i(12'h005, 5'd1, 3'b000, 5'd16, rv_isa_pkg::OPC_OP_IMM), 64'h118, 5'd16,
              64'd5, 5'd0, 1);
    cur.ms_rd = 5'd5;
    cur.src2 = 2'd1;
    tbl.push_back(cur);
    new_issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd17, 7'h33), 64'h11c, 5'd17, 0, 5'd0, 1);
    cur.allowin = 1'b0;
    tbl.push_back(cur);
    new_issue(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd18, 7'h33), 64'h120, 5'd18, 0, 5'd0, 1);
    cur.ws_rd = 5'd1;
    cur.stall = 1'b1;
    tbl.push_back(cur);
    new_issue(enc_b(13'h010, 5'd7, 5'd6, 3'b000), 64'h1000, 0, 64'h10, 5'd0, 0);
    cur.taken = 1'b1;
    cur.target = 64'h1010;
    tbl.push_back(cur);
    new_issue(enc_b(13'h1ff8, 5'd6, 5'd5, 3'b000), 64'h1004, 0, 64'hffff_ffff_ffff_fff8, 0, 0);
    tbl.push_back(cur);
    new_issue(enc_b(13'h020, 5'd6, 5'd5, 3'b001), 64'h1008, 0, 64'h20, 5'd0, 0);
    cur.taken = 1'b1;
    cur.target = 64'h1028;
    tbl.push_back(cur);
    new_issue(enc_b(13'h1f00, 5'd6, 5'd5, 3'b100), 64'h100c, 0, 64'hffff_ffff_ffff_ff00, 0, 0);
    cur.taken = 1'b1;
    cur.target = 64'h0f0c;
    tbl.push_back(cur);
    new_issue(enc_b(13'h040, 5'd6, 5'd5, 3'b111), 64'h1010, 0, 64'h40, 5'd0, 0);
    cur.taken = 1'b1;
    cur.target = 64'h1050;
    tbl.push_back(cur);
    new_issue(enc_b(13'h040, 5'd5, 5'd6, 3'b111), 64'h1014, 0, 64'h40, 5'd0, 0);
    tbl.push_back(cur);
    new_issue(enc_b(13'h020, 5'd7, 5'd6, 3'b001), 64'h1018, 0, 64'h20, 5'd0, 0);
    tbl.push_back(cur);
    new_issue(enc_b(13'h1f00, 5'd5, 5'd6, 3'b100), 64'h101c, 0, 64'hffff_ffff_ffff_ff00, 0, 0);
    tbl.push_back(cur);
    new_issue(enc_j(21'h000800, 5'd1), 64'h2000, 5'd1, 64'h800, 5'd0, 1);
    cur.taken = 1'b1;
    cur.target = 64'h2800;
    cur.src2 = 2'd2;
    cur.pcsel = 1'b1;
    tbl.push_back(cur);
    new_issue(enc_i(12'h010, 5'd6, 3'b000, 5'd1, rv_isa_pkg::OPC_JALR), 64'h2004, 5'd1,
              64'h10, 5'd0, 1);
    cur.taken = 1'b1;
    cur.target = 64'h16;
    cur.src2 = 2'd2;
    cur.pcsel = 1'b1;
    tbl.push_back(cur);
    new_issue(enc_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd3, 7'h7f), 64'h3000, 0, 0, 5'd0, 0);
    cur.inv = 1'b1;
    tbl.push_back(cur);
    new_issue(enc_i(12'h008, 5'd1, 3'b011, 5'd20, rv_isa_pkg::OPC_LOAD), 64'h3004, 5'd20,
              64'd8, 5'd0, 1);
    cur.mren = 1'b1;
    cur.mop = 3'b011;
    cur.src2 = 2'd1;
    tbl.push_back(cur);
    new_issue(enc_s(12'h010, 5'd2, 5'd1, 3'b011), 64'h3008, 0, 64'd16, 5'd0, 0);
    cur.mwen = 1'b1;
    cur.mop = 3'b011;
    cur.src2 = 2'd1;
    tbl.push_back(cur);
    tbl_ready = 1'b1;
  end

  initial begin
    wait (tbl_ready);
    #(tbl.size() * 4 * 100 + 20000);
    $display("timeout: run did not finish in the expected time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    i_rst_n = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_to_ds_bus = '0;
    i_es_allowin = 1'b1;
    i_ws_to_rf = '0;
    i_es_rd = '0;
    i_ms_rd = '0;
    i_ws_rd = '0;
    wait (tbl_ready);
    repeat (3) @(posedge i_clk);
    #5;
    i_rst_n = 1'b1;
    @(negedge i_clk);
    check("reset o_ds_to_es_valid", o_ds_to_es_valid, 1'b0);
    check("reset taken", o_br_bus.taken, 1'b0);
    check("reset o_ds_allowin", o_ds_allowin, 1'b1);
    foreach (tbl[n]) apply_row(tbl[n]);
    repeat (2) @(posedge i_clk);
    $display("rows: %0d errors: %0d", tbl.size(), errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/rv_isa_pkg.sv
design/id_bus_pkg.sv
design/id_decoder.sv
design/id_gpr_file.sv
design/id_branch_unit.sv
design/id_stage_ctrl.sv
design/id_stage.sv
verif/tb_id_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_id_stage -f src.f -o sim_id_stage \
  && ./obj_dir/sim_id_stage | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
